// File: logic/cuPkg.sv
package cuPkg;

    // microaddress space
    localparam int StateWidth = 7;
    localparam int StoreDepth = 128;

    // one microinstruction
    localparam int WordWidth = 45;

    // instruction opcode as seen by decode
    localparam int OpcodeWidth = 6;
    // decode lands in the upper half of the store
    localparam int DecodeBase = 64;

    // condition inputs and their select field
    localparam int CondWidth = 4;
    localparam int SelWidth = $clog2(CondWidth);

    // sequencing code field
    localparam int SeqCodeWidth = 3;

    // datapath bits ahead of CR in the sequencing view
    localparam int DpWidth = WordWidth - StateWidth - 2 - SelWidth - SeqCodeWidth;

    // next address selection codes
    localparam logic [SeqCodeWidth-1:0] SeqFetch = 3'd0;
    localparam logic [SeqCodeWidth-1:0] SeqDecode = 3'd1;
    localparam logic [SeqCodeWidth-1:0] SeqJump = 3'd2;
    localparam logic [SeqCodeWidth-1:0] SeqInc = 3'd3;
    localparam logic [SeqCodeWidth-1:0] SeqBranch = 3'd4;
    localparam logic [SeqCodeWidth-1:0] SeqWait = 3'd5;

    // host write port
    localparam int AxiAddrWidth = 8;
    localparam int AxiDataWidth = 32;
    localparam int AxiStrbWidth = AxiDataWidth / 8;
    // bits carried by the second beat of a word
    localparam int HighWidth = WordWidth - AxiDataWidth;
    localparam logic [1:0] RespOkay = 2'd0;
    localparam logic [1:0] RespSlvErr = 2'd2;

    // datapath view, msb first
    typedef struct packed {
        logic                    IRld;
        logic                    PCld;
        logic                    nPCld;
        logic                    RFld;
        logic                    MA;
        logic [1:0]              MB;
        logic                    MC;
        logic                    ME;
        logic                    MF;
        logic [1:0]              MPA;
        logic                    MP;
        logic                    MR;
        logic                    RW;
        logic                    MOV;
        logic                    MDRld;
        logic                    MARld;
        logic [5:0]              OpC;
        logic                    Cin;
        logic [1:0]              SSE;
        logic [3:0]              OP;
        logic [StateWidth-1:0]   CR;
        logic                    Inv;
        logic                    IncRld;
        logic [SelWidth-1:0]     S;
        logic [SeqCodeWidth-1:0] N;
    } dpViewT;

    // sequencing view, datapath part left opaque
    typedef struct packed {
        logic [DpWidth-1:0]      datapath;
        logic [StateWidth-1:0]   CR;
        logic                    Inv;
        // IncRld position
        logic                    spare;
        logic [SelWidth-1:0]     S;
        logic [SeqCodeWidth-1:0] N;
    } seqViewT;

    typedef union packed {
        dpViewT  dp;
        seqViewT seq;
    } microWordT;

endpackage

// File: logic/microStore.sv
`timescale 1ns/10ps

module microStore (
    input  logic                           clk,
    input  logic                           rst,
    // write address channel
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [cuPkg::AxiAddrWidth-1:0] awaddr,
    // write data channel
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [cuPkg::AxiDataWidth-1:0] wdata,
    input  logic [cuPkg::AxiStrbWidth-1:0] wstrb,
    // write response channel
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    // sequencer read side
    input  logic [cuPkg::StateWidth-1:0]   readAddr,
    output cuPkg::microWordT               readWord
);

    import cuPkg::*;

    // one microinstruction per address
    microWordT               store [StoreDepth];
    // low half parked until the high half commits it
    logic [AxiDataWidth-1:0] staging;

    // handshake
    logic                    accept;

    // decoded write request
    logic                    strbFull;
    logic                    highHalf;
    logic                    highClean;
    logic [StateWidth-1:0]   entry;
    logic                    writeOk;

    // address and data taken together
    // blocked while a response waits for bready
    assign accept = awvalid && wvalid && !bvalid;
    assign awready = accept;
    assign wready = accept;

    // every byte lane must be enabled
    assign strbFull = &wstrb;

    // bit 0 picks the half
    assign highHalf = awaddr[0];

    // high beat only carries 13 bits
    assign highClean = (wdata[AxiDataWidth-1:HighWidth] == '0);

    // word index sits above the half bit
    assign entry = awaddr[StateWidth:1];

    // low beat only needs a full strobe
    assign writeOk = strbFull && (!highHalf || highClean);

    // staging and commit
    always_ff @(posedge clk) begin
        if (accept && writeOk) begin
            if (highHalf) begin
                // high bits plus staged low bits form the entry
                store[entry] <= {wdata[HighWidth-1:0], staging};
            end else begin
                staging <= wdata;
            end
        end
    end

    // response state
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            bresp  <= RespOkay;
        end else if (accept) begin
            // response one cycle after acceptance
            bvalid <= 1'b1;
            bresp  <= writeOk ? RespOkay : RespSlvErr;
        end else if (bready) begin
            // held until the host takes it
            bvalid <= 1'b0;
        end
    end

    // asynchronous read for the sequencer
    assign readWord = store[readAddr];

endmodule

// File: logic/microSequencer.sv
`timescale 1ns/10ps

module microSequencer (
    // instruction opcode for decode
    input  logic [cuPkg::OpcodeWidth-1:0] opcode,
    // condition flags from the datapath
    input  logic [cuPkg::CondWidth-1:0]   cond,
    // microinstruction now in the control register
    input  cuPkg::microWordT              curWord,
    // its address
    input  logic [cuPkg::StateWidth-1:0]  activeState,
    // address to fetch next
    output logic [cuPkg::StateWidth-1:0]  nextState
);

    import cuPkg::*;

    // sequencing fields of the current word
    logic [SeqCodeWidth-1:0] nField;
    logic [SelWidth-1:0]     sField;
    logic                    invBit;
    logic [StateWidth-1:0]   crField;

    // condition path
    logic                    condBit;
    logic                    condTrue;

    // candidate addresses
    logic [StateWidth-1:0]   incState;
    logic [StateWidth-1:0]   decodeState;
    logic [StateWidth-1:0]   branchState;
    logic [StateWidth-1:0]   waitState;

    // read through the sequencing view
    assign nField = curWord.seq.N;
    assign sField = curWord.seq.S;
    assign invBit = curWord.seq.Inv;
    assign crField = curWord.seq.CR;

    // S picks one of the four flags
    assign condBit = cond[sField];

    // Inv flips the sense of the test
    assign condTrue = condBit ^ invBit;

    // incrementer
    // 127 rolls over to 0
    assign incState = activeState + 1'b1;

    // opcode offset into the decode region
    assign decodeState = StateWidth'(DecodeBase) + StateWidth'(opcode);

    // conditional branch
    // taken goes to CR, otherwise fall through
    assign branchState = condTrue ? crField : incState;

    // wait
    // stay put until the condition holds
    assign waitState = condTrue ? incState : activeState;

    // next address mux
    always_comb begin
        case (nField)
            SeqFetch: begin
                // back to the fetch routine
                nextState = '0;
            end
            SeqDecode: begin
                nextState = decodeState;
            end
            SeqJump: begin
                // unconditional
                nextState = crField;
            end
            SeqInc: begin
                nextState = incState;
            end
            SeqBranch: begin
                nextState = branchState;
            end
            SeqWait: begin
                nextState = waitState;
            end
            default: begin
                // 6 and 7 act as plain increment
                nextState = incState;
            end
        endcase
    end

endmodule

// File: logic/controlRegister.sv
`timescale 1ns/10ps

module controlRegister (
    input  logic                           clk,
    input  logic                           rst,
    // advance one microinstruction per clock
    input  logic                           run,
    // word and address chosen by the sequencer
    input  cuPkg::microWordT               nextWord,
    input  logic [cuPkg::StateWidth-1:0]   nextState,
    // datapath control fields
    output logic                           IRld,
    output logic                           PCld,
    output logic                           nPCld,
    output logic                           RFld,
    output logic                           MA,
    output logic [1:0]                     MB,
    output logic                           MC,
    output logic                           ME,
    output logic                           MF,
    output logic [1:0]                     MPA,
    output logic                           MP,
    output logic                           MR,
    output logic                           RW,
    output logic                           MOV,
    output logic                           MDRld,
    output logic                           MARld,
    output logic [5:0]                     OpC,
    output logic                           Cin,
    output logic [1:0]                     SSE,
    output logic [3:0]                     OP,
    // sequencing fields
    output logic [cuPkg::StateWidth-1:0]   CR,
    output logic                           Inv,
    output logic                           IncRld,
    output logic [cuPkg::SelWidth-1:0]     S,
    output logic [cuPkg::SeqCodeWidth-1:0] N,
    // address of the word being executed
    output logic [cuPkg::StateWidth-1:0]   activeState,
    // held word back to the sequencer
    output cuPkg::microWordT               curWord
);

    import cuPkg::*;

    // capture on the rising edge
    // all-zero word means fetch, so entry 0 comes first
    always_ff @(posedge clk) begin
        if (rst) begin
            curWord     <= '0;
            activeState <= '0;
        end else if (run) begin
            curWord     <= nextWord;
            activeState <= nextState;
        end
    end

    // split through the datapath view
    assign IRld = curWord.dp.IRld;
    assign PCld = curWord.dp.PCld;
    assign nPCld = curWord.dp.nPCld;
    assign RFld = curWord.dp.RFld;
    assign MA = curWord.dp.MA;
    assign MB = curWord.dp.MB;
    assign MC = curWord.dp.MC;
    assign ME = curWord.dp.ME;
    assign MF = curWord.dp.MF;
    assign MPA = curWord.dp.MPA;
    assign MP = curWord.dp.MP;
    assign MR = curWord.dp.MR;
    assign RW = curWord.dp.RW;
    assign MOV = curWord.dp.MOV;
    assign MDRld = curWord.dp.MDRld;
    assign MARld = curWord.dp.MARld;
    assign OpC = curWord.dp.OpC;
    assign Cin = curWord.dp.Cin;
    assign SSE = curWord.dp.SSE;
    assign OP = curWord.dp.OP;
    assign CR = curWord.dp.CR;
    assign Inv = curWord.dp.Inv;
    assign IncRld = curWord.dp.IncRld;
    assign S = curWord.dp.S;
    assign N = curWord.dp.N;

endmodule

// File: logic/controlUnit.sv
`timescale 1ns/10ps

module controlUnit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           run,
    input  logic [cuPkg::OpcodeWidth-1:0]  opcode,
    input  logic [cuPkg::CondWidth-1:0]    cond,
    // host write channel into the microstore
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [cuPkg::AxiAddrWidth-1:0] awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  logic [cuPkg::AxiDataWidth-1:0] wdata,
    input  logic [cuPkg::AxiStrbWidth-1:0] wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output logic [1:0]                     bresp,
    // control fields to the datapath
    output logic                           IRld,
    output logic                           PCld,
    output logic                           nPCld,
    output logic                           RFld,
    output logic                           MA,
    output logic [1:0]                     MB,
    output logic                           MC,
    output logic                           ME,
    output logic                           MF,
    output logic [1:0]                     MPA,
    output logic                           MP,
    output logic                           MR,
    output logic                           RW,
    output logic                           MOV,
    output logic                           MDRld,
    output logic                           MARld,
    output logic [5:0]                     OpC,
    output logic                           Cin,
    output logic [1:0]                     SSE,
    output logic [3:0]                     OP,
    output logic [cuPkg::StateWidth-1:0]   CR,
    output logic                           Inv,
    output logic                           IncRld,
    output logic [cuPkg::SelWidth-1:0]     S,
    output logic [cuPkg::SeqCodeWidth-1:0] N,
    output logic [cuPkg::StateWidth-1:0]   activeState
);

    import cuPkg::*;

    // sequencer choice, feeds store read and register capture
    logic [StateWidth-1:0] nextState;
    // word at nextState straight out of the store
    microWordT             storeWord;
    // word held in the control register
    microWordT             curWord;

    microStore store (
        .clk      (clk),
        .rst      (rst),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .readAddr (nextState),
        .readWord (storeWord)
    );

    microSequencer sequencer (
        .opcode      (opcode),
        .cond        (cond),
        .curWord     (curWord),
        .activeState (activeState),
        .nextState   (nextState)
    );

    controlRegister ctrlReg (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .nextWord    (storeWord),
        .nextState   (nextState),
        .IRld        (IRld),
        .PCld        (PCld),
        .nPCld       (nPCld),
        .RFld        (RFld),
        .MA          (MA),
        .MB          (MB),
        .MC          (MC),
        .ME          (ME),
        .MF          (MF),
        .MPA         (MPA),
        .MP          (MP),
        .MR          (MR),
        .RW          (RW),
        .MOV         (MOV),
        .MDRld       (MDRld),
        .MARld       (MARld),
        .OpC         (OpC),
        .Cin         (Cin),
        .SSE         (SSE),
        .OP          (OP),
        .CR          (CR),
        .Inv         (Inv),
        .IncRld      (IncRld),
        .S           (S),
        .N           (N),
        .activeState (activeState),
        .curWord     (curWord)
    );

endmodule

// File: tests/microProgram.svh
`ifndef MICRO_PROGRAM_SVH
`define MICRO_PROGRAM_SVH

// columns: address 7, datapath 31, CR 7, Inv, IncRld, S 2, N 3
localparam int ProgLen = 12;
localparam logic [51:0] ProgTable [ProgLen] = '{
    // fetch routine, plain increment
    {7'd0,  31'h6000_0001, 7'd0, 1'b0, 1'b1, 2'd0, 3'd3},
    // decode by opcode
    {7'd1,  31'h0810_2042, 7'd0, 1'b0, 1'b0, 2'd0, 3'd1},
    // branch to 4 on cond[1]
    {7'd2,  31'h1234_5678, 7'd4, 1'b0, 1'b0, 2'd1, 3'd4},
    {7'd3,  31'h0000_7F00, 7'd0, 1'b0, 1'b1, 2'd0, 3'd3},
    // wait for cond[2]
    {7'd4,  31'h2A00_0A0A, 7'd0, 1'b0, 1'b0, 2'd2, 3'd5},
    {7'd5,  31'h0145_0000, 7'd0, 1'b0, 1'b0, 2'd0, 3'd0},
    // opcode 0, jump back to 2
    {7'd64, 31'h7FFF_FFFF, 7'd2, 1'b0, 1'b1, 2'd0, 3'd2},
    // opcode 1, branch to 5 when cond[3] is low
    {7'd65, 31'h0000_0001, 7'd5, 1'b1, 1'b0, 2'd3, 3'd4},
    // wait while cond[0] is high
    {7'd66, 31'h5555_5555, 7'd0, 1'b1, 1'b0, 2'd0, 3'd5},
    // spare codes 6 and 7
    {7'd67, 31'h3C3C_0000, 7'd0, 1'b0, 1'b1, 2'd1, 3'd6},
    {7'd68, 31'h0000_C3C3, 7'd0, 1'b0, 1'b0, 2'd2, 3'd7},
    // CR set but ignored by fetch
    {7'd69, 31'h1111_1111, 7'd9, 1'b0, 1'b0, 2'd3, 3'd0}
};

// columns: run, opcode 6, cond 4 for one cycle
localparam int StimLen = 40;
localparam logic [10:0] StimTable [StimLen] = '{
    // fetch, decode op 0, jump, branch not taken, inc
    {1'b1, 6'd0, 4'h0}, {1'b1, 6'd5, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd3, 4'hF},
    {1'b1, 6'd0, 4'h9}, {1'b1, 6'd0, 4'h2},
    // wait holds twice then advances
    {1'b1, 6'd0, 4'hB}, {1'b1, 6'd0, 4'h3}, {1'b1, 6'd0, 4'h4}, {1'b1, 6'd0, 4'h0},
    // decode op 1, inverted branch not taken, inverted wait
    {1'b1, 6'd0, 4'h0}, {1'b1, 6'd1, 4'h0}, {1'b1, 6'd0, 4'h8}, {1'b1, 6'd0, 4'h1},
    {1'b1, 6'd0, 4'hF}, {1'b1, 6'd0, 4'hE}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0},
    // branch taken, then run dropped for three cycles
    {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0},
    {1'b1, 6'd0, 4'h2}, {1'b1, 6'd0, 4'h4}, {1'b0, 6'd63, 4'hF}, {1'b0, 6'd9, 4'h5},
    {1'b0, 6'd1, 4'hA}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd1, 4'h0},
    // inverted branch taken, decode op 2, one frozen cycle
    {1'b1, 6'd0, 4'h7}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd2, 4'h0},
    {1'b1, 6'd0, 4'h0}, {1'b0, 6'd4, 4'h0}, {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0},
    {1'b1, 6'd0, 4'h0}, {1'b1, 6'd0, 4'h0}
};

`endif

// File: tests/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb;

    import cuPkg::*;

    `include "microProgram.svh"

    // drive, accept, up to three bready stalls, response
    localparam int WriteCycles = 6;
    // program beats plus the six error path writes
    localparam int WriteCount = 2 * ProgLen + 6;
    localparam int CycleLimit = 2 * WriteCount * WriteCycles + StimLen + 100;

    logic        clk;
    logic        rst;
    logic        run;
    logic [5:0]  opcode;
    logic [3:0]  cond;
    logic        awvalid;
    logic        awready;
    logic [7:0]  awaddr;
    logic        wvalid;
    logic        wready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        bvalid;
    logic        bready;
    logic [1:0]  bresp;
    // single bit control fields
    logic        IRld, PCld, nPCld, RFld, MA, MC, ME, MF, MP, MR, RW, MOV,
                 MDRld, MARld, Cin, Inv, IncRld;
    logic [1:0]  MB;
    logic [1:0]  MPA;
    logic [5:0]  OpC;
    logic [1:0]  SSE;
    logic [3:0]  OP;
    logic [6:0]  CR;
    logic [1:0]  S;
    logic [2:0]  N;
    logic [6:0]  activeState;

    int          seed = 32'h817d8623;
    int          cycleCount = 0;

    controlUnit uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop if a handshake never comes
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Some tests failed");
            $fatal(1, "timeout, run did not finish within %0d cycles", CycleLimit);
        end
    end

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error %s expected %h got %h", name, expected, actual);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // field positions msb first with the datapath part in 44:14
    task automatic checkState(input logic [6:0] expState, input logic [44:0] w);
        checkValue("activeState", expState, activeState);
        checkValue("IRld", w[44], IRld);
        checkValue("PCld", w[43], PCld);
        checkValue("nPCld", w[42], nPCld);
        checkValue("RFld", w[41], RFld);
        checkValue("MA", w[40], MA);
        checkValue("MB", w[39:38], MB);
        checkValue("MC", w[37], MC);
        checkValue("ME", w[36], ME);
        checkValue("MF", w[35], MF);
        checkValue("MPA", w[34:33], MPA);
        checkValue("MP", w[32], MP);
        checkValue("MR", w[31], MR);
        checkValue("RW", w[30], RW);
        checkValue("MOV", w[29], MOV);
        checkValue("MDRld", w[28], MDRld);
        checkValue("MARld", w[27], MARld);
        checkValue("OpC", w[26:21], OpC);
        checkValue("Cin", w[20], Cin);
        checkValue("SSE", w[19:18], SSE);
        checkValue("OP", w[17:14], OP);
        checkValue("CR", w[13:7], CR);
        checkValue("Inv", w[6], Inv);
        checkValue("IncRld", w[5], IncRld);
        checkValue("S", w[4:3], S);
        checkValue("N", w[2:0], N);
    endtask

    // next microaddress from N, S, Inv and CR
    function automatic logic [6:0] predictNext(input logic [6:0] state, input logic [44:0] w,
                                               input logic [5:0] opc, input logic [3:0] flags);
        logic [6:0] plusOne;
        logic       hit;
        plusOne = state + 7'd1;
        hit = flags[w[4:3]] ^ w[6];
        case (w[2:0])
            3'd0: return 7'd0;
            // decode region starts at 64
            3'd1: return 7'd64 + {1'b0, opc};
            3'd2: return w[13:7];
            3'd4: return hit ? w[13:7] : plusOne;
            3'd5: return hit ? plusOne : state;
            default: return plusOne;
        endcase
    endfunction

    function automatic logic [44:0] wordAt(input logic [6:0] addr);
        logic [44:0] found;
        // no expected word for an unprogrammed entry
        found = 'x;
        for (int i = 0; i < ProgLen; i++) begin
            if (ProgTable[i][51:45] == addr) begin
                found = ProgTable[i][44:0];
            end
        end
        return found;
    endfunction

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [1:0] expResp);
        int delay;
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= strb;
        do begin
            @(posedge clk);
        end while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // host stalls the response a few cycles
        delay = $random(seed) & 3;
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!bvalid);
        bready <= 1'b0;
        checkValue("bresp", expResp, bresp);
    endtask

    // low beat then high beat per entry
    task automatic loadProgram();
        logic [6:0]  addr;
        logic [44:0] word;
        for (int i = 0; i < ProgLen; i++) begin
            addr = ProgTable[i][51:45];
            word = ProgTable[i][44:0];
            axiWrite({addr, 1'b0}, word[31:0], 4'hF, RespOkay);
            axiWrite({addr, 1'b1}, {19'd0, word[44:32]}, 4'hF, RespOkay);
        end
    endtask

    initial begin
        logic [6:0]  modelState;
        logic [44:0] modelWord;
        logic [44:0] entryWord;
        logic        rowRun;
        logic [5:0]  rowOpcode;
        logic [3:0]  rowCond;
        rst     <= 1'b1;
        run     <= 1'b0;
        opcode  <= '0;
        cond    <= '0;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '0;
        bready  <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        modelState = '0;
        modelWord = '0;
        // idle with run low keeps everything at zero
        repeat (4) begin
            @(negedge clk);
            checkState(modelState, modelWord);
        end
        loadProgram();
        // junk staged for entry 3 and its high beat rejected
        axiWrite(8'h06, 32'hDEAD_BEEF, 4'hF, RespOkay);
        axiWrite(8'h07, 32'h0000_2001, 4'hF, RespSlvErr);
        // partial strobe on the high beat of entry 5
        axiWrite(8'h0B, 32'h0000_0001, 4'b0111, RespSlvErr);
        // good low beat of entry 4, a rejected partial one, then its high beat
        entryWord = wordAt(7'd4);
        axiWrite(8'h08, entryWord[31:0], 4'hF, RespOkay);
        axiWrite(8'h08, 32'h0BAD_0BAD, 4'b1110, RespSlvErr);
        axiWrite(8'h09, {19'd0, entryWord[44:32]}, 4'hF, RespOkay);
        @(negedge clk);
        checkState(modelState, modelWord);
        // each row checks the capture made with the row before it
        for (int i = 0; i < StimLen; i++) begin
            {rowRun, rowOpcode, rowCond} = StimTable[i];
            @(posedge clk);
            run    <= rowRun;
            opcode <= rowOpcode;
            cond   <= rowCond;
            @(negedge clk);
            checkState(modelState, modelWord);
            if (rowRun) begin
                modelState = predictNext(modelState, modelWord, rowOpcode, rowCond);
                modelWord = wordAt(modelState);
            end
        end
        @(posedge clk);
        run <= 1'b0;
        @(negedge clk);
        checkState(modelState, modelWord);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+tests
logic/cuPkg.sv
logic/microStore.sv
logic/microSequencer.sv
logic/controlRegister.sv
logic/controlUnit.sv
tests/controlUnitTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module controlUnitTb -o controlUnitTb
./obj_dir/controlUnitTb | tee sim.log
if grep -q "All tests passed" sim.log; then
    echo "simulation PASS"
    exit 0
else
    echo "simulation FAIL"
    exit 1
fi
